// File: src.f
logic/complexFirPkg.sv
logic/coeffLoader.sv
logic/coeffBank.sv
logic/firDatapath.sv
logic/complexFirTop.sv
test/complexFir_assert.sv
test/complexFirTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the complex FIR testbench with Verilator and runs it.
# The run passes only if the testbench prints its pass message.

set -u

cd "$(dirname "$0")" || exit 1

TOP=complexFirTb
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module "$TOP" -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

if [ ! -x "$BUILD_DIR/V$TOP" ]; then
	echo "simulation binary not found"
	exit 1
fi

output=$("./$BUILD_DIR/V$TOP" +verilator+error+limit+100)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

// File: test/complexFirTb.sv
// Complex FIR testbench
`timescale 1ns/1ps
`default_nettype none

module complexFirTb;

	import complexFirPkg::*;

	// Cycle budget of each test. The watchdog allows their sum.
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_SAMPLES = 1000;
	localparam int LOAD_BUDGET = TAP_COUNT + 30;
	localparam int GATING_BUDGET = 2 * TAP_COUNT + 40;
	localparam int IMPULSE_BUDGET = 4 * (TAP_COUNT + 1) + 100;
	localparam int RANDOM_BUDGET = 3 * RANDOM_SAMPLES + 200;
	localparam int DROP_BUDGET = 6 * TAP_COUNT + 200;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + LOAD_BUDGET + GATING_BUDGET
		+ IMPULSE_BUDGET + RANDOM_BUDGET + DROP_BUDGET;

	logic clock;
	logic rst;
	logic enable;
	logic sampleValid;
	logic signed [DATA_WIDTH-1:0] sampleRe;
	logic signed [DATA_WIDTH-1:0] sampleIm;
	logic coeffReady;
	logic outValid;
	logic signed [ACC_WIDTH-1:0] outRe;
	logic signed [ACC_WIDTH-1:0] outIm;

	// Reference history of accepted samples, newest first, and the results still owed.
	int histRe [TAP_COUNT];
	int histIm [TAP_COUNT];
	logic signed [ACC_WIDTH-1:0] expRe [$];
	logic signed [ACC_WIDTH-1:0] expIm [$];

	int errorCount;
	int checkCount;
	int testCount;

	complexFirTop u_dut (
		.clock(clock),
		.rst(rst),
		.enable(enable),
		.sampleValid(sampleValid),
		.sampleRe(sampleRe),
		.sampleIm(sampleIm),
		.coeffReady(coeffReady),
		.outValid(outValid),
		.outRe(outRe),
		.outIm(outIm)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	// Moves to 5 ns past the next rising edge, where all inputs are driven.
	task automatic nextCycle();
		@(posedge clock);
		#5;
	endtask

	task automatic compareAcc(input string name, input logic signed [ACC_WIDTH-1:0] expected,
		input logic signed [ACC_WIDTH-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic compareBit(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	// Shifts an accepted sample into the history and queues the output it must produce.
	// Each tap product is (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	task automatic modelAccept(input int re, input int im);
		int accRe;
		int accIm;
		for (int k = TAP_COUNT - 1; k > 0; k--) begin
			histRe[k] = histRe[k - 1];
			histIm[k] = histIm[k - 1];
		end
		histRe[0] = re;
		histIm[0] = im;
		accRe = 0;
		accIm = 0;
		for (int k = 0; k < TAP_COUNT; k++) begin
			accRe += int'(COEFF_RE[k]) * histRe[k] - int'(COEFF_IM[k]) * histIm[k];
			accIm += int'(COEFF_RE[k]) * histIm[k] + int'(COEFF_IM[k]) * histRe[k];
		end
		expRe.push_back(ACC_WIDTH'(accRe));
		expIm.push_back(ACC_WIDTH'(accIm));
	endtask

	// The next edge takes the sample only if the ready flag is high now.
	// The flag is registered, so its value now is the one that edge sees.
	task automatic sendSample(input logic signed [DATA_WIDTH-1:0] re,
		input logic signed [DATA_WIDTH-1:0] im);
		sampleValid = 1'b1;
		sampleRe = re;
		sampleIm = im;
		if (coeffReady) modelAccept(int'(re), int'(im));
		nextCycle();
		sampleValid = 1'b0;
	endtask

	task automatic idleCycles(input int count);
		sampleValid = 1'b0;
		repeat (count) nextCycle();
	endtask

	// Extremes come up often, the rest is any byte.
	function automatic logic signed [DATA_WIDTH-1:0] randomPart();
		case ($urandom_range(7, 0))
			0: return DATA_WIDTH'(127);
			1: return DATA_WIDTH'(-128);
			2: return DATA_WIDTH'(-127);
			default: return DATA_WIDTH'($urandom);
		endcase
	endfunction

	// Waits until every queued result has come out, then a few quiet cycles.
	task automatic waitDrain(input int limit);
		int waited;
		waited = 0;
		while (expRe.size() != 0 && waited < limit) begin
			nextCycle();
			waited++;
		end
		if (expRe.size() != 0) begin
			errorCount++;
			$display("%0d expected results never appeared within %0d cycles", expRe.size(), limit);
			expRe.delete();
			expIm.delete();
		end
		idleCycles(PIPE_LATENCY + 2);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("test %s finished at %0t ns, errors so far %0d", name, $time, errorCount);
	endtask

	// Outputs are stable at the falling edge.
	always @(negedge clock) begin
		if (!rst && outValid === 1'b1) begin
			if (expRe.size() == 0) begin
				errorCount++;
				$display("outValid pulsed at %0t ns with no accepted sample behind it", $time);
			end else begin
				compareAcc("outRe", expRe.pop_front(), outRe);
				compareAcc("outIm", expIm.pop_front(), outIm);
			end
		end
	end

	task automatic testResetState();
		compareBit("coeffReady", 1'b0, coeffReady);
		compareBit("outValid", 1'b0, outValid);
		finishTest("reset state");
	endtask

	// The first edge after raising enable is E0, and the flag must read high after E13.
	task automatic testLoadTiming();
		enable = 1'b1;
		for (int n = 0; n <= TAP_COUNT + 1; n++) begin
			nextCycle();
			compareBit("coeffReady", n == TAP_COUNT + 1, coeffReady);
		end
		repeat (8) begin
			nextCycle();
			compareBit("coeffReady", 1'b1, coeffReady);
		end
		finishTest("load timing");
	endtask

	// A one cycle drop restarts the load, and samples during it must yield nothing.
	task automatic testGating();
		enable = 1'b0;
		nextCycle();
		compareBit("coeffReady", 1'b0, coeffReady);
		enable = 1'b1;
		for (int n = 0; n < GATING_BUDGET && !coeffReady; n++) sendSample(randomPart(), randomPart());
		if (!coeffReady) begin
			errorCount++;
			$display("coeffReady did not rise again after enable was restored");
		end
		idleCycles(PIPE_LATENCY + 2);
		finishTest("gating before ready");
	endtask

	// Unit impulses read the table back, plain and rotated by j.
	task automatic testImpulse();
		sendSample(DATA_WIDTH'(1), '0);
		repeat (TAP_COUNT) sendSample('0, '0);
		waitDrain(IMPULSE_BUDGET / 2);
		sendSample('0, DATA_WIDTH'(1));
		repeat (TAP_COUNT) sendSample('0, '0);
		waitDrain(IMPULSE_BUDGET / 2);
		finishTest("impulse response");
	endtask

	// First half runs back to back, second half has random gaps.
	task automatic testRandomStream();
		for (int n = 0; n < RANDOM_SAMPLES; n++) begin
			sendSample(randomPart(), randomPart());
			if (n >= RANDOM_SAMPLES / 2 && $urandom_range(3, 0) == 0) begin
				idleCycles(int'($urandom_range(3, 1)));
			end
		end
		waitDrain(RANDOM_BUDGET - 2 * RANDOM_SAMPLES);
		finishTest("random stream");
	endtask

	// Enable falls together with a valid sample, which is still taken.
	// The history carries over the reload, as the delay line is not cleared.
	task automatic testEnableDrop();
		repeat (6) sendSample(randomPart(), randomPart());
		enable = 1'b0;
		sendSample(randomPart(), randomPart());
		compareBit("coeffReady", 1'b0, coeffReady);
		enable = 1'b1;
		for (int n = 0; n < 2 * TAP_COUNT && !coeffReady; n++) sendSample(randomPart(), randomPart());
		if (!coeffReady) begin
			errorCount++;
			$display("coeffReady did not rise after the reload");
		end
		repeat (2 * TAP_COUNT) sendSample(randomPart(), randomPart());
		waitDrain(DROP_BUDGET / 2);
		finishTest("enable drop");
	endtask

	initial begin
		int seedValue;
		int totalErrors;
		seedValue = $urandom(22);
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		for (int k = 0; k < TAP_COUNT; k++) begin
			histRe[k] = 0;
			histIm[k] = 0;
		end
		rst = 1'b1;
		enable = 1'b0;
		sampleValid = 1'b0;
		sampleRe = '0;
		sampleIm = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		#5;
		rst = 1'b0;
		testResetState();
		testLoadTiming();
		testGating();
		testImpulse();
		testRandomStream();
		testEnableDrop();
		totalErrors = errorCount + u_dut.u_assert.assertFailures;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			testCount, checkCount, errorCount, u_dut.u_assert.assertFailures);
		if (totalErrors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/complexFir_assert.sv
// Complex FIR timing assertions
`timescale 1ns/1ps
`default_nettype none

module complexFirAssert (
	input  wire logic clock,
	input  wire logic rst,
	input  wire logic enable,
	input  wire logic sampleValid,
	input  wire logic coeffReady,
	input  wire logic outValid
);

	import complexFirPkg::*;

	// Consecutive edges that sampled enable high, saturating well above a load.
	int enabledEdges;

	// Number of failed assertions, summed into the closing count.
	int assertFailures = 0;

	always_ff @(posedge clock) begin
		if (rst || !enable) begin
			enabledEdges <= 0;
		end else if (enabledEdges < 1000) begin
			enabledEdges <= enabledEdges + 1;
		end
	end

	// A sample accepted at one edge is seen as outValid two edges later.
	outTiming: assert property (@(posedge clock) disable iff (rst)
		outValid == $past(sampleValid && coeffReady, PIPE_LATENCY))
		else begin
			assertFailures++;
			$error("outValid does not follow an accepted sample by two edges");
		end

	// Edges E0 through E13 all saw enable before the new flag is sampled at E14.
	readyNotEarly: assert property (@(posedge clock) disable iff (rst)
		$rose(coeffReady) |-> enabledEdges >= TAP_COUNT + 2)
		else begin
			assertFailures++;
			$error("coeffReady rose before a full coefficient load");
		end

	// The flag clears at the edge that sees enable low.
	readyNeedsEnable: assert property (@(posedge clock) disable iff (rst)
		!enable |=> !coeffReady)
		else begin
			assertFailures++;
			$error("coeffReady stayed high with enable low");
		end

endmodule

bind complexFirTop complexFirAssert u_assert (
	.clock(clock),
	.rst(rst),
	.enable(enable),
	.sampleValid(sampleValid),
	.coeffReady(coeffReady),
	.outValid(outValid)
);

`default_nettype wire

// File: logic/complexFirTop.sv
// Complex FIR top level
`timescale 1ns/1ps
`default_nettype none

module complexFirTop (
	input  wire logic clock,
	input  wire logic rst,
	input  wire logic enable,
	input  wire logic sampleValid,
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] sampleRe,
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] sampleIm,
	output logic coeffReady,
	output logic outValid,
	output logic signed [complexFirPkg::ACC_WIDTH-1:0] outRe,
	output logic signed [complexFirPkg::ACC_WIDTH-1:0] outIm
);

	import complexFirPkg::*;

	// Coefficient stream from the loader into the bank.
	logic coeffShift;
	logic signed [DATA_WIDTH-1:0] coeffRe;
	logic signed [DATA_WIDTH-1:0] coeffIm;

	// Ready flag, which also gates sample acceptance in the datapath.
	logic coeffSetFlag;

	// All taps, presented in parallel.
	logic signed [DATA_WIDTH-1:0] tapRe [TAP_COUNT];
	logic signed [DATA_WIDTH-1:0] tapIm [TAP_COUNT];

	coeffLoader u_loader (
		.clock(clock),
		.rst(rst),
		.enable(enable),
		.coeffShift(coeffShift),
		.coeffSetFlag(coeffSetFlag),
		.coeffRe(coeffRe),
		.coeffIm(coeffIm)
	);

	coeffBank u_bank (
		.clock(clock),
		.rst(rst),
		.coeffShift(coeffShift),
		.coeffRe(coeffRe),
		.coeffIm(coeffIm),
		.tapRe(tapRe),
		.tapIm(tapIm)
	);

	firDatapath u_datapath (
		.clock(clock),
		.rst(rst),
		.coeffSetFlag(coeffSetFlag),
		.sampleValid(sampleValid),
		.sampleRe(sampleRe),
		.sampleIm(sampleIm),
		.tapRe(tapRe),
		.tapIm(tapIm),
		.outValid(outValid),
		.outRe(outRe),
		.outIm(outIm)
	);

	// The ready flag is exported as is.
	assign coeffReady = coeffSetFlag;

endmodule

`default_nettype wire

// File: logic/firDatapath.sv
// Complex FIR datapath
`timescale 1ns/1ps
`default_nettype none

module firDatapath (
	input  wire logic clock,
	input  wire logic rst,
	input  wire logic coeffSetFlag,
	input  wire logic sampleValid,
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] sampleRe,
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] sampleIm,
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] tapRe [complexFirPkg::TAP_COUNT],
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] tapIm [complexFirPkg::TAP_COUNT],
	output logic outValid,
	output logic signed [complexFirPkg::ACC_WIDTH-1:0] outRe,
	output logic signed [complexFirPkg::ACC_WIDTH-1:0] outIm
);

	import complexFirPkg::*;

	// A sample is taken only while the taps are known to be complete.
	logic accept;

	// Past samples, newest first.
	// The incoming sample is position 0, so TAP_COUNT - 1 stored entries give
	// the full TAP_COUNT deep window.
	logic signed [DATA_WIDTH-1:0] histRe [TAP_COUNT - 1];
	logic signed [DATA_WIDTH-1:0] histIm [TAP_COUNT - 1];

	// The window seen by the multipliers at an accepting edge.
	logic signed [DATA_WIDTH-1:0] winRe [TAP_COUNT];
	logic signed [DATA_WIDTH-1:0] winIm [TAP_COUNT];

	// Complex products, before and after the stage one register.
	logic signed [PROD_WIDTH-1:0] nextProdRe [TAP_COUNT];
	logic signed [PROD_WIDTH-1:0] nextProdIm [TAP_COUNT];
	logic signed [PROD_WIDTH-1:0] prodRe [TAP_COUNT];
	logic signed [PROD_WIDTH-1:0] prodIm [TAP_COUNT];

	// Sums of the registered products, before the stage two register.
	logic signed [ACC_WIDTH-1:0] sumRe;
	logic signed [ACC_WIDTH-1:0] sumIm;

	// Bit 0 marks stage one holding products, bit 1 marks stage two holding sums.
	logic [PIPE_LATENCY-1:0] validPipe;

	assign accept = sampleValid && coeffSetFlag;

	// Build the window from the new sample and the stored history.
	always_comb begin
		winRe[0] = sampleRe;
		winIm[0] = sampleIm;
		for (int k = 1; k < TAP_COUNT; k++) begin
			winRe[k] = histRe[k - 1];
			winIm[k] = histIm[k - 1];
		end
	end

	// Complex multiply per tap.
	// Operands are sign extended to the product width first, so nothing overflows.
	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	always_comb begin
		for (int k = 0; k < TAP_COUNT; k++) begin
			nextProdRe[k] = PROD_WIDTH'(winRe[k]) * PROD_WIDTH'(tapRe[k])
				- PROD_WIDTH'(winIm[k]) * PROD_WIDTH'(tapIm[k]);
			nextProdIm[k] = PROD_WIDTH'(winRe[k]) * PROD_WIDTH'(tapIm[k])
				+ PROD_WIDTH'(winIm[k]) * PROD_WIDTH'(tapRe[k]);
		end
	end

	// Adder tree over all taps, kept at full precision.
	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < TAP_COUNT; k++) begin
			sumRe = sumRe + ACC_WIDTH'(prodRe[k]);
			sumIm = sumIm + ACC_WIDTH'(prodIm[k]);
		end
	end

	// The delay line shifts only on acceptance.
	// It is cleared by reset alone and so keeps its contents across a reload.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < TAP_COUNT - 1; k++) begin
				histRe[k] <= '0;
				histIm[k] <= '0;
			end
		end else if (accept) begin
			histRe[0] <= sampleRe;
			histIm[0] <= sampleIm;
			for (int k = 1; k < TAP_COUNT - 1; k++) begin
				histRe[k] <= histRe[k - 1];
				histIm[k] <= histIm[k - 1];
			end
		end
	end

	// Stage one captures the products in the same edge that takes the sample.
	always_ff @(posedge clock) begin
		if (accept) begin
			prodRe <= nextProdRe;
			prodIm <= nextProdIm;
		end
	end

	// Stage two captures the sums one edge later.
	always_ff @(posedge clock) begin
		if (validPipe[0]) begin
			outRe <= sumRe;
			outIm <= sumIm;
		end
	end

	// The valid chain runs freely, so results in flight still emerge
	// after the ready flag drops.
	always_ff @(posedge clock) begin
		if (rst) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[PIPE_LATENCY-2:0], accept};
		end
	end

	// A sample taken at edge S is summed at S+1 and is seen as outValid at S+2.
	assign outValid = validPipe[PIPE_LATENCY-1];

endmodule

`default_nettype wire

// File: logic/coeffBank.sv
// Coefficient tap registers
`timescale 1ns/1ps
`default_nettype none

module coeffBank (
	input  wire logic clock,
	input  wire logic rst,
	input  wire logic coeffShift,
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] coeffRe,
	input  wire logic signed [complexFirPkg::DATA_WIDTH-1:0] coeffIm,
	output logic signed [complexFirPkg::DATA_WIDTH-1:0] tapRe [complexFirPkg::TAP_COUNT],
	output logic signed [complexFirPkg::DATA_WIDTH-1:0] tapIm [complexFirPkg::TAP_COUNT]
);

	import complexFirPkg::*;

	// Two shift registers, one per complex part, advancing together.
	// The newest coefficient enters at the top tap and older ones move down.
	// After TAP_COUNT shifts the first streamed coefficient sits in tap 0.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < TAP_COUNT; k++) begin
				tapRe[k] <= '0;
				tapIm[k] <= '0;
			end
		end else if (coeffShift) begin
			for (int k = 0; k < TAP_COUNT - 1; k++) begin
				tapRe[k] <= tapRe[k + 1];
				tapIm[k] <= tapIm[k + 1];
			end
			tapRe[TAP_COUNT - 1] <= coeffRe;
			tapIm[TAP_COUNT - 1] <= coeffIm;
		end
	end

	// During a reload the taps hold a mix of old and new values.
	// That is harmless because the datapath accepts no samples until the
	// loader raises its flag, and the flag rises only after the full load.

	// No other state lives here.
	// All taps are presented in parallel to the multipliers every cycle.

endmodule

`default_nettype wire

// File: logic/coeffLoader.sv
// Coefficient table loader
`timescale 1ns/1ps
`default_nettype none

module coeffLoader (
	input  wire logic clock,
	input  wire logic rst,
	input  wire logic enable,
	output logic coeffShift,
	output logic coeffSetFlag,
	output logic signed [complexFirPkg::DATA_WIDTH-1:0] coeffRe,
	output logic signed [complexFirPkg::DATA_WIDTH-1:0] coeffIm
);

	import complexFirPkg::*;

	// Counts the edges seen with enable high during a load.
	// A count of 0 means idle, counts 1 to TAP_COUNT emit the table, and
	// TAP_COUNT + 1 means the load is finished.
	logic [COUNT_WIDTH-1:0] count;

	// Table index emitted at the current edge.
	// It trails the count by one, since the first enabled edge only arms the loader.
	logic [COUNT_WIDTH-1:0] tapIndex;

	// High once every table entry has been sent.
	logic loadDone;

	assign tapIndex = count - COUNT_WIDTH'(1);
	assign loadDone = (count == COUNT_WIDTH'(TAP_COUNT + 1));

	always_ff @(posedge clock) begin
		if (rst || !enable) begin
			// Dropping enable returns the loader to idle.
			// A later rise of enable reloads from index 0.
			count <= '0;
			coeffShift <= 1'b0;
			coeffSetFlag <= 1'b0;
			coeffRe <= '0;
			coeffIm <= '0;
		end else if (loadDone) begin
			// The last coefficient was shifted into the bank at this same edge.
			// So the taps are complete whenever the flag reads high.
			coeffShift <= 1'b0;
			coeffSetFlag <= 1'b1;
		end else begin
			count <= count + COUNT_WIDTH'(1);

			// The first enabled edge only starts the count.
			if (count != '0) begin
				coeffShift <= 1'b1;
				coeffRe <= COEFF_RE[tapIndex];
				coeffIm <= COEFF_IM[tapIndex];
			end
		end
	end

	// Timing of one load, with E0 the first edge that sees enable high.
	// Edges E1 through E12 register coefficients 0 through 11 with the strobe high.
	// The bank takes them at edges E2 through E13.
	// At E13 the strobe drops and the ready flag rises together.
	// The flag then holds for as long as enable stays high.

	// Unlike a plain compare against the table length, the finished state
	// stops the counter, so it never wraps and never restarts a load by itself.

endmodule

`default_nettype wire

// File: logic/complexFirPkg.sv
// Complex FIR shared definitions
`default_nettype none

package complexFirPkg;

	// Width of one real or imaginary part of a sample or a coefficient.
	localparam int DATA_WIDTH = 8;

	// Number of filter taps.
	localparam int TAP_COUNT = 12;

	// One complex product part is the difference or sum of two full products.
	// That takes one bit more than a single product.
	localparam int PROD_WIDTH = 2 * DATA_WIDTH + 1;

	// Summing TAP_COUNT products grows the word by the ceiling log2 of the tap count.
	localparam int ACC_WIDTH = PROD_WIDTH + $clog2(TAP_COUNT);

	// The loader counter must reach TAP_COUNT + 1, which marks a finished load.
	localparam int COUNT_WIDTH = $clog2(TAP_COUNT + 1);

	// Edges from sample acceptance until the summed result is registered.
	localparam int PIPE_LATENCY = 2;

	// Real parts of the coefficient table, index 0 first.
	// Index 0 is streamed first and ends up in tap 0.
	localparam logic signed [DATA_WIDTH-1:0] COEFF_RE [TAP_COUNT] = '{
		8'sd3,
		8'sd2,
		8'sd17,
		8'sd0,
		8'sd55,
		8'sd120,
		8'sd123,
		8'sd56,
		-8'sd99,
		-8'sd109,
		8'sd23,
		-8'sd60
	};

	// Imaginary parts, matching COEFF_RE entry for entry.
	localparam logic signed [DATA_WIDTH-1:0] COEFF_IM [TAP_COUNT] = '{
		8'sd7, 8'sd0, 8'sd5, -8'sd3,
		-8'sd103, -8'sd111, -8'sd24, 8'sd96,
		-8'sd32, -8'sd76, -8'sd14, 8'sd10
	};

endpackage

`default_nettype wire
